// ==== capture_buffer.sv ====
//////////////////////////////
// Capture buffer
// Ring memory of the selected channel with the
// capture FSM and a trigger-relative read port
//////////////////////////////

module capture_buffer import scope_pkg::*; (
    input  logic                      clock,
    input  logic                      arst_n,
    input  sel_sample_t               sel,
    input  scope_cfg_t                cfg,
    input  logic                      arm,
    input  logic                      buf_rd,
    input  logic [buf_addr_width-1:0] buf_index,
    output logic                      trig_enable,
    output buf_read_t                 status
);

    logic [sample_width-1:0] mem [buf_depth];
    cap_state_t state;
    logic [buf_addr_width-1:0] wr_ptr;
    logic [buf_addr_width-1:0] count;
    logic [buf_addr_width-1:0] trig_addr;
    logic [buf_addr_width-1:0] post_len;
    logic [buf_addr_width-1:0] rd_addr;
    logic [sample_width-1:0] rd_data;
    logic rd_valid;
    logic mem_we;

    // Samples after the trigger that complete one full ring
    assign post_len = buf_addr_width'(buf_depth - 1) - cfg.pretrig;

    // Only the three capture states store, and an arm edge drops its sample
    assign mem_we = sel.valid && !arm &&
        (state == cap_prefill || state == cap_armed || state == cap_post);

    // The engine may only fire while the pre-trigger part is full
    assign trig_enable = state == cap_armed;

    always_ff @(posedge clock or negedge arst_n) begin
        if (!arst_n) begin
            state <= cap_idle;
            wr_ptr <= '0;
            count <= '0;
            trig_addr <= '0;
        end else if (arm) begin
            // A new arm restarts from any state, including a running capture
            state <= (cfg.pretrig == '0) ? cap_armed : cap_prefill;
            wr_ptr <= '0;
            count <= '0;
        end else if (mem_we) begin
            wr_ptr <= wr_ptr + 1'b1;
            case (state)
                cap_prefill: begin
                    if (count == cfg.pretrig - 1'b1) begin
                        state <= cap_armed;
                        count <= '0;
                    end else begin
                        count <= count + 1'b1;
                    end
                end
                cap_armed: begin
                    // The trigger sample lands at the current write pointer
                    if (sel.trigger) begin
                        trig_addr <= wr_ptr;
                        count <= '0;
                        state <= (post_len == '0) ? cap_done : cap_post;
                    end
                end
                cap_post: begin
                    if (count == post_len - 1'b1) begin
                        state <= cap_done;
                    end else begin
                        count <= count + 1'b1;
                    end
                end
                default: begin
                end
            endcase
        end
    end

    always_ff @(posedge clock) begin
        if (mem_we) begin
            mem[wr_ptr] <= sel.data;
        end
    end

    // Index 0 is the oldest pre-trigger sample, wrapping around the ring
    assign rd_addr = trig_addr - cfg.pretrig + buf_index;

    always_ff @(posedge clock) begin
        if (buf_rd) begin
            rd_data <= mem[rd_addr];
        end
    end

    always_ff @(posedge clock or negedge arst_n) begin
        if (!arst_n) begin
            rd_valid <= 1'b0;
        end else begin
            rd_valid <= buf_rd;
        end
    end

    assign status.rd_data = rd_data;
    assign status.rd_valid = rd_valid;
    assign status.done = state == cap_done;
    assign status.trig_addr = trig_addr;

endmodule

// ==== run.sh ====
#!/bin/sh
# Build and run the scope testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f vlog.f --top-module tb_scope
if [ $? -ne 0 ]; then
    echo "Verilator build error"
    exit 1
fi

out=$(./obj_dir/Vtb_scope)
status=$?
echo "$out"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if echo "$out" | grep -qx "Testbench passed"; then
    exit 0
fi
echo "Pass message not found in the simulation output"
exit 1

// ==== scope_pkg.sv ====
//////////////////////////////
// Scope package
// Shared sizes, encodings and bus structs for the
// acquisition core and its testbench
//////////////////////////////

package scope_pkg;

    // Four channels arrive together in every sample frame
    localparam int n_channels = 4;
    localparam int sample_width = 16;

    // The capture ring holds one channel only
    localparam int buf_depth = 64;
    localparam int buf_addr_width = 6;

    // Crossing rule applied by the trigger engine
    typedef enum logic [1:0] {
        trig_rising,
        trig_falling,
        trig_both,
        trig_off
    } trig_mode_t;

    // Register map of the strobe bus, one word per address
    typedef enum logic [2:0] {
        reg_mode = 3'd0,
        reg_level = 3'd1,
        reg_channel = 3'd2,
        reg_pretrig = 3'd3,
        reg_control = 3'd4,
        reg_status = 3'd5
    } reg_addr_t;

    // Capture sequence after an arm command
    typedef enum logic [2:0] {
        cap_idle,
        cap_prefill,
        cap_armed,
        cap_post,
        cap_done
    } cap_state_t;

    // One frame carries every channel under a single valid bit
    typedef struct packed {
        logic valid;
        logic [n_channels-1:0][sample_width-1:0] samples;
    } sample_frame_t;

    // A register access is a single-cycle write or read strobe
    typedef struct packed {
        logic write;
        logic read;
        reg_addr_t addr;
        logic [31:0] wdata;
    } reg_req_t;

    typedef struct packed {
        trig_mode_t mode;
        logic [sample_width-1:0] level;
        logic [1:0] channel;
        logic [buf_addr_width-1:0] pretrig;
    } scope_cfg_t;

    // Selected channel sample, tagged when it fires the trigger
    typedef struct packed {
        logic valid;
        logic trigger;
        logic [sample_width-1:0] data;
    } sel_sample_t;

    // Read port result plus the fields shown in the status word
    typedef struct packed {
        logic [sample_width-1:0] rd_data;
        logic rd_valid;
        logic done;
        logic [buf_addr_width-1:0] trig_addr;
    } buf_read_t;

endpackage

// ==== scope_regs.sv ====
//////////////////////////////
// Scope register block
// Holds the trigger settings, answers reads one
// cycle late and turns control writes into arm
//////////////////////////////

module scope_regs import scope_pkg::*; (
    input  logic        clock,
    input  logic        arst_n,
    input  reg_req_t    reg_in,
    input  buf_read_t   status,
    output scope_cfg_t  cfg,
    output logic        arm,
    output logic [31:0] reg_rdata,
    output logic        reg_rvalid
);

    logic [31:0] rd_word;

    // The control register is not stored, bit 0 acts at the write edge itself
    assign arm = reg_in.write && reg_in.addr == reg_control && reg_in.wdata[0];

    // Settings follow the write strobe and are masked to their field widths
    always_ff @(posedge clock or negedge arst_n) begin
        if (!arst_n) begin
            cfg <= '0;
        end else if (reg_in.write) begin
            case (reg_in.addr)
                reg_mode: begin
                    cfg.mode <= trig_mode_t'(reg_in.wdata[1:0]);
                end
                reg_level: begin
                    cfg.level <= reg_in.wdata[sample_width-1:0];
                end
                reg_channel: begin
                    cfg.channel <= reg_in.wdata[1:0];
                end
                reg_pretrig: begin
                    cfg.pretrig <= reg_in.wdata[buf_addr_width-1:0];
                end
                default: begin
                end
            endcase
        end
    end

    // Read mux, zero extended fields and the status word
    // Status puts done in bit 8 and the trigger address in the low bits
    always_comb begin
        rd_word = '0;
        case (reg_in.addr)
            reg_mode:    rd_word[1:0] = cfg.mode;
            reg_level:   rd_word[sample_width-1:0] = cfg.level;
            reg_channel: rd_word[1:0] = cfg.channel;
            reg_pretrig: rd_word[buf_addr_width-1:0] = cfg.pretrig;
            reg_status: begin
                rd_word[8] = status.done;
                rd_word[buf_addr_width-1:0] = status.trig_addr;
            end
            default:     rd_word = '0;
        endcase
    end

    // Read data comes back exactly one cycle after the strobe
    always_ff @(posedge clock or negedge arst_n) begin
        if (!arst_n) begin
            reg_rvalid <= 1'b0;
            reg_rdata <= '0;
        end else begin
            reg_rvalid <= reg_in.read;
            if (reg_in.read) begin
                reg_rdata <= rd_word;
            end
        end
    end

endmodule

// ==== scope_top.sv ====
//////////////////////////////
// Scope acquisition core
// Registers, trigger engine and capture buffer
//////////////////////////////

module scope_top import scope_pkg::*; (
    input  logic                      clock,
    input  logic                      arst_n,
    input  sample_frame_t             frame_in,
    input  reg_req_t                  reg_in,
    output logic [31:0]               reg_rdata,
    output logic                      reg_rvalid,
    input  logic                      buf_rd,
    input  logic [buf_addr_width-1:0] buf_index,
    output logic [sample_width-1:0]   buf_data,
    output logic                      buf_valid,
    output logic                      done
);

    scope_cfg_t cfg;
    logic arm;
    logic trig_enable;
    sel_sample_t sel;
    buf_read_t status;

    // Settings and the arm strobe come from the register bus
    scope_regs u_scope_regs (
        .clock      (clock),
        .arst_n     (arst_n),
        .reg_in     (reg_in),
        .status     (status),
        .cfg        (cfg),
        .arm        (arm),
        .reg_rdata  (reg_rdata),
        .reg_rvalid (reg_rvalid)
    );

    trigger_engine u_trigger_engine (
        .clock       (clock),
        .arst_n      (arst_n),
        .frame_in    (frame_in),
        .cfg         (cfg),
        .trig_enable (trig_enable),
        .sel         (sel)
    );

    // The buffer paces the engine through trig_enable
    capture_buffer u_capture_buffer (
        .clock       (clock),
        .arst_n      (arst_n),
        .sel         (sel),
        .cfg         (cfg),
        .arm         (arm),
        .buf_rd      (buf_rd),
        .buf_index   (buf_index),
        .trig_enable (trig_enable),
        .status      (status)
    );

    assign buf_data = status.rd_data;
    assign buf_valid = status.rd_valid;
    assign done = status.done;

endmodule

// ==== tb_scope.sv ====
//////////////////////////////
// Scope core testbench
// Random frames and register traffic, checked
// against a capture model kept in the testbench
//////////////////////////////

module tb_scope import scope_pkg::*; ();

    logic clock;
    logic arst_n;
    sample_frame_t frame_in;
    reg_req_t reg_in;
    logic [31:0] reg_rdata;
    logic reg_rvalid;
    logic buf_rd;
    logic [buf_addr_width-1:0] buf_index;
    logic [sample_width-1:0] buf_data;
    logic buf_valid;
    logic done;

    // Model state, a copy of the settings and the record since the last arm
    trig_mode_t m_mode;
    logic [15:0] m_level;
    logic [1:0] m_channel;
    int m_pretrig;
    logic [15:0] prev;
    logic capturing;
    int trig_idx;
    logic [15:0] cap_q [$];
    logic [31:0] lfsr;
    int n_tests;
    int n_checks;
    int n_errors;

    scope_top u_scope_top (
        .clock      (clock),
        .arst_n     (arst_n),
        .frame_in   (frame_in),
        .reg_in     (reg_in),
        .reg_rdata  (reg_rdata),
        .reg_rvalid (reg_rvalid),
        .buf_rd     (buf_rd),
        .buf_index  (buf_index),
        .buf_data   (buf_data),
        .buf_valid  (buf_valid),
        .done       (done)
    );

    always #20 clock = ~clock;

    // Galois LFSR, one step per bit handed out
    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] r;
        r = '0;
        for (int i = 0; i < n; i++) begin
            lfsr = {1'b0, lfsr[31:1]} ^ (lfsr[0] ? 32'h80200003 : 32'h0);
            r = {r[30:0], lfsr[0]};
        end
        return r;
    endfunction

    task automatic check(input string name, input logic [31:0] exp, input logic [31:0] act);
        n_checks++;
        if (exp !== act) begin
            n_errors++;
            $display("ERR %s expected %h actual %h", name, exp, act);
        end
    endtask

    task automatic abort(input string what);
        $display("Timeout: %s", what);
        $display("Testbench failed");
        $finish;
    endtask

    task automatic finish_test(input string name, input int errs_before);
        n_tests++;
        $display("%s: %0d errors", name, n_errors - errs_before);
    endtask

    // Crossing rules of the trigger modes
    function automatic logic crosses(input logic [15:0] p, input logic [15:0] c);
        logic up;
        logic down;
        up = p < m_level && c >= m_level;
        down = p > m_level && c <= m_level;
        case (m_mode)
            trig_rising: return up;
            trig_falling: return down;
            trig_both: return up || down;
            default: return 1'b0;
        endcase
    endfunction

    // The first crossing after the pre-trigger part marks the trigger sample
    function automatic void model_sample(input logic [15:0] cur);
        if (capturing && trig_idx < 0 && cap_q.size() >= m_pretrig && crosses(prev, cur)) begin
            trig_idx = cap_q.size();
        end
        if (capturing) begin
            cap_q.push_back(cur);
        end
        prev = cur;
    endfunction

    // One valid frame, always followed by at least one idle cycle
    task automatic send_frame();
        logic [n_channels-1:0][sample_width-1:0] smp;
        repeat (rand_bits(2)) @(negedge clock);
        for (int c = 0; c < n_channels; c++) begin
            smp[c] = 16'(rand_bits(16));
        end
        @(negedge clock);
        frame_in.valid = 1'b1;
        frame_in.samples = smp;
        @(negedge clock);
        frame_in.valid = 1'b0;
        model_sample(smp[m_channel]);
    endtask

    task automatic reg_write(input reg_addr_t addr, input logic [31:0] data);
        @(negedge clock);
        reg_in.write = 1'b1;
        reg_in.addr = addr;
        reg_in.wdata = data;
        @(negedge clock);
        reg_in = '0;
    endtask

    task automatic read_reg(input string name, input reg_addr_t addr, output logic [31:0] data);
        int t;
        @(negedge clock);
        reg_in.read = 1'b1;
        reg_in.addr = addr;
        @(negedge clock);
        reg_in = '0;
        t = 0;
        while (!reg_rvalid) begin
            if (t == 8) abort("reg_rvalid never rose after a read");
            @(negedge clock);
            t++;
        end
        // Data is due exactly one cycle after the strobe
        check(name, 32'h0, 32'(t));
        data = reg_rdata;
    endtask

    task automatic read_buffer(input string name, input logic [5:0] k, output logic [31:0] data);
        int t;
        @(negedge clock);
        buf_rd = 1'b1;
        buf_index = k;
        @(negedge clock);
        buf_rd = 1'b0;
        t = 0;
        while (!buf_valid) begin
            if (t == 8) abort("buf_valid never rose after a buffer read");
            @(negedge clock);
            t++;
        end
        check(name, 32'h0, 32'(t));
        data = {16'd0, buf_data};
    endtask

    task automatic configure(input trig_mode_t mode, input logic [15:0] level,
                             input logic [1:0] channel, input logic [5:0] pretrig);
        reg_write(reg_mode, {30'd0, mode});
        reg_write(reg_level, {16'd0, level});
        reg_write(reg_channel, {30'd0, channel});
        reg_write(reg_pretrig, {26'd0, pretrig});
        m_mode = mode;
        m_level = level;
        m_channel = channel;
        m_pretrig = int'(pretrig);
    endtask

    // Arm restarts the model record as well
    task automatic arm_capture();
        reg_write(reg_control, 32'd1);
        cap_q.delete();
        trig_idx = -1;
        capturing = 1'b1;
    endtask

    task automatic wait_done();
        int t;
        t = 0;
        while (!done) begin
            if (t == 3000) abort("done never rose during a capture");
            send_frame();
            t++;
        end
    endtask

    // Index k must hold the record entry pretrig before the trigger plus k
    task automatic verify_buffer(input string name);
        logic [31:0] r;
        int base;
        if (trig_idx < 0 || cap_q.size() < trig_idx - m_pretrig + buf_depth) begin
            $display("%s: done rose before the model saw a full record", name);
            n_checks++;
            n_errors++;
        end else begin
            read_reg(name, reg_status, r);
            check(name, 32'h100 | 32'(trig_idx % buf_depth), r);
            base = trig_idx - m_pretrig;
            for (int k = 0; k < buf_depth; k++) begin
                read_buffer(name, 6'(k), r);
                check(name, {16'd0, cap_q[base + k]}, r);
            end
        end
    endtask

    task automatic capture_test(input string name, input trig_mode_t mode,
                                input logic [5:0] pretrig);
        int errs;
        logic [15:0] level;
        errs = n_errors;
        // Levels stay mid range so crossings come often
        level = 16'h4000 + 16'(rand_bits(15));
        configure(mode, level, 2'(rand_bits(2)), pretrig);
        arm_capture();
        wait_done();
        verify_buffer(name);
        finish_test(name, errs);
    endtask

    initial begin
        logic [31:0] d;
        logic [31:0] r;
        logic [31:0] masks [4];
        logic seen;
        int errs;
        clock = 1'b0;
        arst_n = 1'b0;
        frame_in = '0;
        reg_in = '0;
        buf_rd = 1'b0;
        buf_index = '0;
        lfsr = 32'hdf81163b;
        prev = '0;
        capturing = 1'b0;
        trig_idx = -1;
        n_tests = 0;
        n_checks = 0;
        n_errors = 0;
        masks = '{32'h3, 32'hffff, 32'h3, 32'h3f};
        repeat (16) @(posedge clock);
        @(negedge clock);
        arst_n = 1'b1;

        // Mode, level, channel and pretrig hold only their field widths
        errs = n_errors;
        for (int a = 0; a < 4; a++) begin
            d = rand_bits(32);
            reg_write(reg_addr_t'(3'(a)), d);
            read_reg("register readback", reg_addr_t'(3'(a)), r);
            check("register readback", d & masks[a], r);
        end
        read_reg("register readback", reg_addr_t'(3'd7), r);
        check("register readback", 32'h0, r);
        finish_test("register readback", errs);

        capture_test("rising capture", trig_rising, 6'(rand_bits(6)));
        capture_test("falling capture", trig_falling, 6'(rand_bits(6)));
        capture_test("both capture", trig_both, 6'(rand_bits(6)));

        // With the trigger off the capture never leaves the armed state
        errs = n_errors;
        configure(trig_off, 16'h8000, 2'(rand_bits(2)), 6'(rand_bits(6)));
        arm_capture();
        seen = 1'b0;
        repeat (200) begin
            send_frame();
            seen = seen | done;
        end
        check("off mode", 32'h0, {31'd0, seen});
        read_reg("off mode", reg_status, r);
        check("off mode", 32'h0, r & 32'h100);
        finish_test("off mode", errs);

        // A second arm in the middle of a capture starts the record over
        errs = n_errors;
        configure(trig_rising, 16'h4000 + 16'(rand_bits(15)), 2'(rand_bits(2)),
                  6'd16 + 6'(rand_bits(5)));
        arm_capture();
        repeat (m_pretrig + 2) send_frame();
        check("re-arm", 32'h0, {31'd0, done});
        arm_capture();
        wait_done();
        verify_buffer("re-arm");
        finish_test("re-arm", errs);

        $display("Summary: %0d tests, %0d checks, %0d errors", n_tests, n_checks, n_errors);
        if (n_errors == 0) begin
            $display("Testbench passed");
        end else begin
            $display("Testbench failed");
        end
        $finish;
    end

endmodule

// ==== tb_scope_assert.sv ====
//////////////////////////////
// Capture buffer assertions
// Trigger gating, write gating and read latency
//////////////////////////////

module tb_scope_assert import scope_pkg::*; (
    input logic                      clock,
    input logic                      arst_n,
    input cap_state_t                state,
    input logic                      trig_enable,
    input logic                      mem_we,
    input logic                      sel_trigger,
    input logic                      arm,
    input logic [buf_addr_width-1:0] wr_ptr,
    input logic                      buf_rd,
    input logic                      rd_valid
);

    // The trigger window opens only at an arm or at the end of prefill
    a_trig_open: assert property (@(posedge clock) disable iff (!arst_n)
        $rose(trig_enable) |-> $past(arm || state == cap_prefill))
        else $error("trig_enable rose outside an arm or the end of prefill");

    // It closes only on a stored trigger sample or on a new arm
    a_trig_enable: assert property (@(posedge clock) disable iff (!arst_n)
        $fell(trig_enable) |-> $past(arm || (sel_trigger && mem_we)))
        else $error("trig_enable dropped without a stored trigger or an arm");

    // Idle and done must leave the ring untouched, so the pointer and the FSM rest
    a_no_write: assert property (@(posedge clock) disable iff (!arst_n)
        (state == cap_idle || state == cap_done) && !arm |=> $stable(wr_ptr) && $stable(state))
        else $error("memory write in idle or done");

    // Read data valid is the read strobe delayed by one cycle
    a_rd_latency: assert property (@(posedge clock) disable iff (!arst_n)
        rd_valid == $past(buf_rd))
        else $error("buffer read valid does not follow buf_rd by one cycle");

endmodule

bind capture_buffer tb_scope_assert u_tb_scope_assert (
    .clock       (clock),
    .arst_n      (arst_n),
    .state       (state),
    .trig_enable (trig_enable),
    .mem_we      (mem_we),
    .sel_trigger (sel.trigger),
    .arm         (arm),
    .wr_ptr      (wr_ptr),
    .buf_rd      (buf_rd),
    .rd_valid    (status.rd_valid)
);

// ==== trigger_engine.sv ====
//////////////////////////////
// Trigger engine
// Selects one channel and flags level crossings
// against the previous valid sample
//////////////////////////////

module trigger_engine import scope_pkg::*; (
    input  logic          clock,
    input  logic          arst_n,
    input  sample_frame_t frame_in,
    input  scope_cfg_t    cfg,
    input  logic          trig_enable,
    output sel_sample_t   sel
);

    logic [sample_width-1:0] cur_sample;
    logic [sample_width-1:0] prev_sample;
    logic rising_edge;
    logic falling_edge;
    logic hit;

    // Channel multiplexer driven by the configured index
    assign cur_sample = frame_in.samples[cfg.channel];

    // Rising needs the old sample strictly below the level
    assign rising_edge = prev_sample < cfg.level && cur_sample >= cfg.level;

    // Falling is the mirror case, from strictly above
    assign falling_edge = prev_sample > cfg.level && cur_sample <= cfg.level;

    // The mode picks which crossing counts
    always_comb begin
        case (cfg.mode)
            trig_rising: begin
                hit = rising_edge;
            end
            trig_falling: begin
                hit = falling_edge;
            end
            trig_both: begin
                hit = rising_edge || falling_edge;
            end
            default: begin
                hit = 1'b0;
            end
        endcase
    end

    // History of the selected channel
    // It moves on every valid frame, armed or not, so the first
    // armed sample is compared with a real predecessor
    always_ff @(posedge clock or negedge arst_n) begin
        if (!arst_n) begin
            prev_sample <= '0;
        end else if (frame_in.valid) begin
            prev_sample <= cur_sample;
        end
    end

    // Registered output stage, one cycle from frame to buffer
    // Data is held on idle cycles so the bus stays quiet
    always_ff @(posedge clock or negedge arst_n) begin
        if (!arst_n) begin
            sel <= '0;
        end else begin
            sel.valid <= frame_in.valid;
            sel.trigger <= frame_in.valid && trig_enable && hit;
            if (frame_in.valid) begin
                sel.data <= cur_sample;
            end
        end
    end

endmodule

// ==== vlog.f ====
scope_pkg.sv
scope_regs.sv
trigger_engine.sv
capture_buffer.sv
scope_top.sv
tb_scope_assert.sv
tb_scope.sv
